// ==== logic/cpuPkg.sv ====
// Shared widths and types for the 16-bit core; encodings cover only the supported subset
package cpuPkg;

	localparam int dataW = 16;
	localparam int regAddrW = 3;

	// Major opcode in bits 15:11
	typedef enum logic [4:0] {
		opHalt = 5'b00000,
		opNop  = 5'b00001,
		opJ    = 5'b00100,
		opAddi = 5'b01000,
		opSubi = 5'b01001,
		opXori = 5'b01010,
		opAndi = 5'b01011,
		opBeqz = 5'b01100,
		opBnez = 5'b01101,
		opSt   = 5'b10000,
		opLd   = 5'b10001,
		opSlbi = 5'b10010,
		opLbi  = 5'b11000,
		opAluR = 5'b11011
	} opcodeT;

	typedef enum logic [1:0] {
		aluAdd,
		aluXor,
		aluAnd,
		aluPass
	} aluOpT;

	typedef struct packed {
		logic regWrite;
		logic aluSrc;
		logic memWrite;
		logic memRead;
		logic memToReg;
		logic branchCtl;
		logic branchOnZero;
		logic jumpCtl;
		logic invA;
		logic invB;
		logic halt;
		// 1 selects imm8, 0 selects imm5
		logic immCtl;
		logic extCtl;
		logic lbi;
		logic slbi;
		aluOpT aluCtl;
		// 0 is bits 7:5, 1 is bits 4:2, 2 is bits 10:8
		logic [1:0] rdSel;
	} ctlT;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [dataW-1:0] paddr;
		logic [dataW-1:0] pwdata;
	} apbReqT;

	typedef struct packed {
		logic [dataW-1:0] prdata;
		logic pready;
	} apbRspT;

	typedef enum logic [1:0] {
		apbIdle,
		apbSetup,
		apbAccess
	} apbStateT;

endpackage

// ==== logic/control.sv ====
// Purely combinational decode; opcodes outside the supported set give all-inactive controls
`timescale 1ns/1ns

module control (
	input logic [15:0] instr,
	output cpuPkg::ctlT ctl
);

	cpuPkg::opcodeT op;
	logic [1:0] func;

	assign op = cpuPkg::opcodeT'(instr[15:11]);
	assign func = instr[1:0];

	always_comb begin
		ctl = '0;
		ctl.aluCtl = cpuPkg::aluAdd;
		case (op)
			cpuPkg::opHalt: begin
				ctl.halt = 1'b1;
			end
			cpuPkg::opAddi: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrc = 1'b1;
				ctl.extCtl = 1'b1;
			end
			// Carry-in from invA turns this into imm - rs
			cpuPkg::opSubi: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrc = 1'b1;
				ctl.extCtl = 1'b1;
				ctl.invA = 1'b1;
			end
			cpuPkg::opXori: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrc = 1'b1;
				ctl.aluCtl = cpuPkg::aluXor;
			end
			cpuPkg::opAndi: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrc = 1'b1;
				ctl.aluCtl = cpuPkg::aluAnd;
			end
			cpuPkg::opAluR: begin
				ctl.regWrite = 1'b1;
				ctl.rdSel = 2'd1;
				case (func)
					// sub is rt - rs
					2'b01: ctl.invA = 1'b1;
					2'b10: ctl.aluCtl = cpuPkg::aluXor;
					2'b11: begin
						ctl.invB = 1'b1;
						ctl.aluCtl = cpuPkg::aluAnd;
					end
					default: ctl.aluCtl = cpuPkg::aluAdd;
				endcase
			end
			cpuPkg::opLbi: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrc = 1'b1;
				ctl.immCtl = 1'b1;
				ctl.extCtl = 1'b1;
				ctl.lbi = 1'b1;
				ctl.rdSel = 2'd2;
			end
			cpuPkg::opSlbi: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrc = 1'b1;
				ctl.immCtl = 1'b1;
				ctl.slbi = 1'b1;
				ctl.rdSel = 2'd2;
			end
			cpuPkg::opSt: begin
				ctl.aluSrc = 1'b1;
				ctl.extCtl = 1'b1;
				ctl.memWrite = 1'b1;
			end
			cpuPkg::opLd: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrc = 1'b1;
				ctl.extCtl = 1'b1;
				ctl.memRead = 1'b1;
				ctl.memToReg = 1'b1;
			end
			cpuPkg::opBeqz: begin
				ctl.branchCtl = 1'b1;
				ctl.branchOnZero = 1'b1;
				ctl.immCtl = 1'b1;
				ctl.extCtl = 1'b1;
				ctl.aluCtl = cpuPkg::aluPass;
			end
			cpuPkg::opBnez: begin
				ctl.branchCtl = 1'b1;
				ctl.immCtl = 1'b1;
				ctl.extCtl = 1'b1;
				ctl.aluCtl = cpuPkg::aluPass;
			end
			cpuPkg::opJ: begin
				ctl.jumpCtl = 1'b1;
				ctl.aluCtl = cpuPkg::aluPass;
			end
			// nop and anything unsupported
			default: ctl = '0;
		endcase
	end

endmodule

// ==== logic/regFile.sv ====
// Eight registers with combinational reads and no write bypass
`timescale 1ns/1ns

module regFile (
	input logic clk,
	input logic rstN,
	input logic [cpuPkg::regAddrW-1:0] rdAddrA,
	input logic [cpuPkg::regAddrW-1:0] rdAddrB,
	input logic wrEn,
	input logic [cpuPkg::regAddrW-1:0] wrAddr,
	input logic [cpuPkg::dataW-1:0] wrData,
	output logic [cpuPkg::dataW-1:0] rdDataA,
	output logic [cpuPkg::dataW-1:0] rdDataB
);

	logic [cpuPkg::dataW-1:0] regs [0:(1 << cpuPkg::regAddrW)-1];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < (1 << cpuPkg::regAddrW); i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

// ==== logic/alu.sv ====
// Subtraction comes from invA plus carry-in; lbi and slbi override the function select
`timescale 1ns/1ns

module alu (
	input logic [cpuPkg::dataW-1:0] opA,
	input logic [cpuPkg::dataW-1:0] opB,
	input logic invA,
	input logic invB,
	input cpuPkg::aluOpT aluCtl,
	input logic lbi,
	input logic slbi,
	output logic [cpuPkg::dataW-1:0] result,
	output logic isZero
);

	logic [cpuPkg::dataW-1:0] inA;
	logic [cpuPkg::dataW-1:0] inB;
	logic [cpuPkg::dataW-1:0] funcOut;

	assign inA = invA ? ~opA : opA;
	assign inB = invB ? ~opB : opB;

	always_comb begin
		case (aluCtl)
			cpuPkg::aluAdd: funcOut = inA + inB + {{(cpuPkg::dataW-1){1'b0}}, invA};
			cpuPkg::aluXor: funcOut = inA ^ inB;
			cpuPkg::aluAnd: funcOut = inA & inB;
			default: funcOut = opA;
		endcase
	end

	always_comb begin
		if (slbi) begin
			result = (opA << 8) | opB;
		end else if (lbi) begin
			result = opB;
		end else begin
			result = funcOut;
		end
	end

	// Branch condition looks at rs directly
	assign isZero = (opA == '0);

endmodule

// ==== logic/apbMaster.sv ====
// Setup phase starts in the instruction's first cycle; request inputs must hold while stalled
`timescale 1ns/1ns

module apbMaster (
	input logic clk,
	input logic rstN,
	input logic memRead,
	input logic memWrite,
	input logic [cpuPkg::dataW-1:0] addr,
	input logic [cpuPkg::dataW-1:0] wrData,
	input cpuPkg::apbRspT apbRsp,
	output cpuPkg::apbReqT apbReq,
	output logic stall,
	output logic [cpuPkg::dataW-1:0] rdData
);

	cpuPkg::apbStateT state;
	cpuPkg::apbStateT phase;
	logic memReq;

	assign memReq = memRead | memWrite;

	// An idle cycle with a pending request is the setup cycle
	always_comb begin
		if (state == cpuPkg::apbIdle && memReq) begin
			phase = cpuPkg::apbSetup;
		end else begin
			phase = state;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= cpuPkg::apbIdle;
		end else begin
			case (phase)
				cpuPkg::apbSetup: state <= cpuPkg::apbAccess;
				cpuPkg::apbAccess: begin
					if (apbRsp.pready) begin
						state <= cpuPkg::apbIdle;
					end
				end
				default: state <= cpuPkg::apbIdle;
			endcase
		end
	end

	always_comb begin
		apbReq.psel = (phase != cpuPkg::apbIdle);
		apbReq.penable = (phase == cpuPkg::apbAccess);
		apbReq.pwrite = memWrite;
		apbReq.paddr = addr;
		apbReq.pwdata = wrData;
	end

	assign stall = (phase == cpuPkg::apbSetup) ||
		(phase == cpuPkg::apbAccess && !apbRsp.pready);

	// Written to the register file on the completing edge
	assign rdData = apbRsp.prdata;

endmodule

// ==== logic/cpuCore.sv ====
// Single-cycle core with byte-addressed PC; instr must be valid combinationally from pc
`timescale 1ns/1ns

module cpuCore (
	input logic clk,
	input logic rstN,
	input logic [15:0] instr,
	input cpuPkg::apbRspT apbRsp,
	output logic [cpuPkg::dataW-1:0] pc,
	output cpuPkg::apbReqT apbReq,
	output logic halted
);

	cpuPkg::ctlT ctl;
	logic [cpuPkg::dataW-1:0] rdDataA;
	logic [cpuPkg::dataW-1:0] rdDataB;
	logic [cpuPkg::dataW-1:0] immExt;
	logic [cpuPkg::dataW-1:0] dispExt;
	logic [cpuPkg::dataW-1:0] aluOpB;
	logic [cpuPkg::dataW-1:0] aluResult;
	logic [cpuPkg::dataW-1:0] memRdData;
	logic [cpuPkg::dataW-1:0] wrData;
	logic [cpuPkg::regAddrW-1:0] wrAddr;
	logic [cpuPkg::dataW-1:0] pcInc;
	logic [cpuPkg::dataW-1:0] pcNext;
	logic isZero;
	logic stall;
	logic takeBranch;
	logic wrEn;

	control uControl (
		.instr(instr),
		.ctl(ctl)
	);

	// Immediate select and extension
	always_comb begin
		if (ctl.immCtl) begin
			immExt = ctl.extCtl ? {{8{instr[7]}}, instr[7:0]} : {8'h00, instr[7:0]};
		end else begin
			immExt = ctl.extCtl ? {{11{instr[4]}}, instr[4:0]} : {11'h000, instr[4:0]};
		end
	end

	assign dispExt = {{5{instr[10]}}, instr[10:0]};

	always_comb begin
		case (ctl.rdSel)
			2'd1: wrAddr = instr[4:2];
			2'd2: wrAddr = instr[10:8];
			default: wrAddr = instr[7:5];
		endcase
	end

	// Port B also supplies the store data from bits 7:5
	regFile uRegFile (
		.clk(clk),
		.rstN(rstN),
		.rdAddrA(instr[10:8]),
		.rdAddrB(instr[7:5]),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB)
	);

	assign aluOpB = ctl.aluSrc ? immExt : rdDataB;

	alu uAlu (
		.opA(rdDataA),
		.opB(aluOpB),
		.invA(ctl.invA),
		.invB(ctl.invB),
		.aluCtl(ctl.aluCtl),
		.lbi(ctl.lbi),
		.slbi(ctl.slbi),
		.result(aluResult),
		.isZero(isZero)
	);

	apbMaster uApbMaster (
		.clk(clk),
		.rstN(rstN),
		.memRead(ctl.memRead),
		.memWrite(ctl.memWrite),
		.addr(aluResult),
		.wrData(rdDataB),
		.apbRsp(apbRsp),
		.apbReq(apbReq),
		.stall(stall),
		.rdData(memRdData)
	);

	assign wrData = ctl.memToReg ? memRdData : aluResult;
	assign wrEn = ctl.regWrite && !stall && !halted;

	assign pcInc = pc + 16'd2;
	assign takeBranch = ctl.branchCtl && (ctl.branchOnZero ? isZero : !isZero);

	always_comb begin
		if (ctl.jumpCtl) begin
			pcNext = pcInc + dispExt;
		end else if (takeBranch) begin
			pcNext = pcInc + immExt;
		end else begin
			pcNext = pcInc;
		end
	end

	// PC stays on the halt instruction once it is reached
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			halted <= 1'b0;
		end else if (!halted) begin
			if (ctl.halt) begin
				halted <= 1'b1;
			end else if (!stall) begin
				pc <= pcNext;
			end
		end
	end

endmodule

// ==== verif/cpuTb.sv ====
// Self-checking test of cpuCore; data memory maps byte address bits 6:1 onto 64 words
`timescale 1ns/1ns

module cpuTb;

	logic clk;
	logic rstN;
	logic [15:0] instr;
	logic [15:0] pc;
	logic halted;
	cpuPkg::apbReqT apbReq;
	cpuPkg::apbRspT apbRsp;

	logic [15:0] prog [0:63];
	logic [15:0] mem [0:63];
	logic [15:0] memInit [0:63];
	logic [15:0] expAddr [$];
	logic [15:0] expData [$];
	logic [15:0] refHaltPc;
	logic refDone;
	integer seed;

	cpuCore u_dut (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.apbRsp(apbRsp),
		.pc(pc),
		.apbReq(apbReq),
		.halted(halted)
	);

	assign instr = prog[pc[6:1]];

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic failNow(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
		failNow("value mismatch");
	endtask

	function automatic logic [15:0] i1Instr(input logic [4:0] op, input logic [2:0] rs,
		input logic [2:0] rd, input logic [4:0] imm5);
		return {op, rs, rd, imm5};
	endfunction

	function automatic logic [15:0] i2Instr(input logic [4:0] op, input logic [2:0] rs,
		input logic [7:0] imm8);
		return {op, rs, imm8};
	endfunction

	function automatic logic [15:0] rInstr(input logic [2:0] rs, input logic [2:0] rt,
		input logic [2:0] rd, input logic [1:0] func);
		return {cpuPkg::opAluR, rs, rt, rd, func};
	endfunction

	function automatic logic [15:0] jInstr(input logic [10:0] disp);
		return {cpuPkg::opJ, disp};
	endfunction

	task automatic placeInstr(input logic [15:0] addr, input logic [15:0] word);
		prog[addr[6:1]] = word;
	endtask

	task automatic loadProgram;
		for (int i = 0; i < 64; i++) begin
			prog[i] = {cpuPkg::opNop, 11'h000};
		end
		placeInstr(0, i2Instr(cpuPkg::opLbi, 1, 8'h12));
		placeInstr(2, i2Instr(cpuPkg::opSlbi, 1, 8'hB4));
		placeInstr(4, i2Instr(cpuPkg::opLbi, 2, 8'hFD));
		placeInstr(6, i1Instr(cpuPkg::opAddi, 1, 3, 5'h1B));
		placeInstr(8, i1Instr(cpuPkg::opSubi, 1, 4, 5'd3));
		placeInstr(10, i1Instr(cpuPkg::opXori, 2, 5, 5'h1F));
		placeInstr(12, i1Instr(cpuPkg::opAndi, 1, 6, 5'h1C));
		// r7 holds the store base at byte address 32
		placeInstr(14, i2Instr(cpuPkg::opLbi, 7, 8'h20));
		placeInstr(16, i1Instr(cpuPkg::opSt, 7, 3, 5'd0));
		placeInstr(18, i1Instr(cpuPkg::opSt, 7, 4, 5'd2));
		placeInstr(20, i1Instr(cpuPkg::opSt, 7, 5, 5'd4));
		placeInstr(22, i1Instr(cpuPkg::opSt, 7, 6, 5'd6));
		placeInstr(24, rInstr(1, 2, 3, 2'b00));
		placeInstr(26, rInstr(1, 2, 4, 2'b01));
		placeInstr(28, rInstr(1, 2, 5, 2'b10));
		placeInstr(30, rInstr(1, 2, 6, 2'b11));
		placeInstr(32, i1Instr(cpuPkg::opSt, 7, 3, 5'd8));
		placeInstr(34, i1Instr(cpuPkg::opSt, 7, 4, 5'd10));
		placeInstr(36, i1Instr(cpuPkg::opSt, 7, 5, 5'd12));
		placeInstr(38, i1Instr(cpuPkg::opSt, 7, 6, 5'd14));
		// Loads from untouched preloaded words with a store after each
		placeInstr(40, i1Instr(cpuPkg::opLd, 7, 3, 5'h10));
		placeInstr(42, i1Instr(cpuPkg::opSt, 7, 3, 5'h12));
		placeInstr(44, i1Instr(cpuPkg::opLd, 0, 4, 5'd14));
		placeInstr(46, i1Instr(cpuPkg::opSt, 7, 4, 5'h14));
		placeInstr(48, i2Instr(cpuPkg::opBeqz, 0, 8'd2));
		placeInstr(50, i1Instr(cpuPkg::opSt, 7, 2, 5'd0));
		placeInstr(52, i2Instr(cpuPkg::opBnez, 0, 8'd4));
		placeInstr(54, i1Instr(cpuPkg::opSt, 7, 1, 5'd2));
		placeInstr(56, i2Instr(cpuPkg::opBnez, 1, 8'd2));
		placeInstr(58, i1Instr(cpuPkg::opSt, 7, 2, 5'd4));
		placeInstr(60, jInstr(11'd4));
		placeInstr(62, i1Instr(cpuPkg::opSt, 7, 1, 5'd8));
		placeInstr(64, i1Instr(cpuPkg::opSt, 7, 1, 5'd8));
		placeInstr(66, i1Instr(cpuPkg::opSt, 7, 2, 5'd6));
		placeInstr(70, {cpuPkg::opHalt, 11'h000});
	endtask

	// Instruction-set model; fills the expected store queues and returns the halt address
	function automatic logic [15:0] runReference(output logic done);
		logic [15:0] regs [0:7];
		logic [15:0] rmem [0:63];
		logic [15:0] rpc;
		logic [15:0] w;
		logic [15:0] rsV;
		logic [15:0] rtV;
		logic [15:0] sImm5;
		logic [15:0] zImm5;
		logic [15:0] sImm8;
		logic [15:0] addr;
		for (int i = 0; i < 8; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < 64; i++) begin
			rmem[i] = memInit[i];
		end
		rpc = '0;
		done = 1'b0;
		for (int step = 0; step < 500 && !done; step++) begin
			w = prog[rpc[6:1]];
			rsV = regs[w[10:8]];
			rtV = regs[w[7:5]];
			sImm5 = {{11{w[4]}}, w[4:0]};
			zImm5 = {11'h000, w[4:0]};
			sImm8 = {{8{w[7]}}, w[7:0]};
			addr = rsV + sImm5;
			case (w[15:11])
				cpuPkg::opHalt: done = 1'b1;
				cpuPkg::opAddi: regs[w[7:5]] = rsV + sImm5;
				cpuPkg::opSubi: regs[w[7:5]] = sImm5 - rsV;
				cpuPkg::opXori: regs[w[7:5]] = rsV ^ zImm5;
				cpuPkg::opAndi: regs[w[7:5]] = rsV & zImm5;
				cpuPkg::opLbi: regs[w[10:8]] = sImm8;
				cpuPkg::opSlbi: regs[w[10:8]] = (rsV << 8) | {8'h00, w[7:0]};
				cpuPkg::opLd: regs[w[7:5]] = rmem[addr[6:1]];
				cpuPkg::opSt: begin
					rmem[addr[6:1]] = rtV;
					expAddr.push_back(addr);
					expData.push_back(rtV);
				end
				cpuPkg::opAluR: begin
					case (w[1:0])
						2'b00: regs[w[4:2]] = rsV + rtV;
						2'b01: regs[w[4:2]] = rtV - rsV;
						2'b10: regs[w[4:2]] = rsV ^ rtV;
						default: regs[w[4:2]] = rsV & ~rtV;
					endcase
				end
				default: ;
			endcase
			if (!done) begin
				if (w[15:11] == cpuPkg::opJ) begin
					rpc = rpc + 2 + {{5{w[10]}}, w[10:0]};
				end else if ((w[15:11] == cpuPkg::opBeqz && rsV == 0) ||
					(w[15:11] == cpuPkg::opBnez && rsV != 0)) begin
					rpc = rpc + 2 + sImm8;
				end else begin
					rpc = rpc + 2;
				end
			end
		end
		return rpc;
	endfunction

	// APB slave that samples at negedge and drives 1 ns after the rising edge
	initial begin : apbSlave
		cpuPkg::apbReqT seen;
		logic seenReady;
		logic [31:0] r;
		int waits;
		waits = 0;
		forever begin
			@(negedge clk);
			seen = apbReq;
			seenReady = apbRsp.pready;
			@(posedge clk);
			#1;
			if (seen.psel && seen.penable && seenReady) begin
				if (seen.pwrite) begin
					mem[seen.paddr[6:1]] = seen.pwdata;
				end
				apbRsp.pready = 1'b0;
			end else if (seen.psel && !seen.penable) begin
				r = $random(seed);
				waits = r[1:0];
				apbRsp.prdata = mem[seen.paddr[6:1]];
				apbRsp.pready = (waits == 0);
			end else if (seen.psel && seen.penable) begin
				waits--;
				apbRsp.pready = (waits == 0);
			end
		end
	end

	// Compares each completed write and checks request stability
	initial begin : apbCompare
		cpuPkg::apbReqT held;
		logic inXfer;
		inXfer = 1'b0;
		forever begin
			@(negedge clk);
			if (!inXfer) begin
				if (apbReq.psel) begin
					assert (!apbReq.penable)
						else failNow("APB access phase without a setup phase");
					held = apbReq;
					inXfer = 1'b1;
				end
			end else begin
				assert (apbReq.psel && apbReq.penable)
					else failNow("psel or penable dropped before pready");
				assert (apbReq.paddr == held.paddr)
					else reportMismatch("paddr", held.paddr, apbReq.paddr);
				assert (apbReq.pwrite == held.pwrite)
					else reportMismatch("pwrite", held.pwrite, apbReq.pwrite);
				assert (!held.pwrite || apbReq.pwdata == held.pwdata)
					else reportMismatch("pwdata", held.pwdata, apbReq.pwdata);
				if (apbRsp.pready) begin
					inXfer = 1'b0;
					if (apbReq.pwrite) begin
						assert (expAddr.size() > 0)
							else failNow("APB write that the reference program never makes");
						assert (apbReq.paddr == expAddr[0])
							else reportMismatch("paddr", expAddr[0], apbReq.paddr);
						assert (apbReq.pwdata == expData[0])
							else reportMismatch("pwdata", expData[0], apbReq.pwdata);
						void'(expAddr.pop_front());
						void'(expData.pop_front());
					end
				end
			end
		end
	end

	initial begin : mainFlow
		int n;
		logic [15:0] lastPc;
		rstN = 1'b0;
		apbRsp = '0;
		seed = 82555;
		for (int i = 0; i < 64; i++) begin
			mem[i] = $random(seed);
			memInit[i] = mem[i];
		end
		loadProgram();
		refHaltPc = runReference(refDone);
		if (!refDone) begin
			failNow("reference model never reached halt");
		end
		repeat (3) @(posedge clk);
		#1 rstN = 1'b1;
		@(negedge clk);
		assert (pc == 16'h0000) else reportMismatch("pc", 16'h0000, pc);
		assert (!apbReq.psel) else reportMismatch("psel", 0, apbReq.psel);
		assert (!apbReq.penable) else reportMismatch("penable", 0, apbReq.penable);
		assert (!halted) else reportMismatch("halted", 0, halted);
		n = 0;
		while (!halted && n < 1000) begin
			@(negedge clk);
			n++;
		end
		if (!halted) begin
			failNow("timeout while waiting for halted");
		end
		assert (pc == refHaltPc) else reportMismatch("pc", refHaltPc, pc);
		lastPc = pc;
		repeat (20) begin
			@(negedge clk);
			assert (pc == lastPc) else reportMismatch("pc", lastPc, pc);
			assert (halted) else reportMismatch("halted", 1, halted);
			assert (!apbReq.psel) else reportMismatch("psel", 0, apbReq.psel);
		end
		if (expAddr.size() != 0) begin
			failNow("reference stores missing from the APB bus");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

// ==== list.f ====
logic/cpuPkg.sv
logic/control.sv
logic/regFile.sv
logic/alu.sv
logic/apbMaster.sv
logic/cpuCore.sv
verif/cpuTb.sv
